// ==== hw/rv_pkg.sv ====
// Widths and the APB address map are fixed here; the instruction RAM holds 512 words
package rv_pkg;

   localparam int XLEN    = 64;
   localparam int ILEN    = 32;
   localparam int IMEM_AW = 9;
   localparam int DMEM_AW = 10;
   localparam int APB_AW  = 16;

   // Byte bases on the APB side
   localparam logic [APB_AW-1:0] IMEM_BASE = 16'h0000;
   localparam logic [APB_AW-1:0] DMEM_BASE = 16'h2000;

   // Supported major opcodes
   localparam logic [6:0] OP_R      = 7'b0110011;
   localparam logic [6:0] OP_IMM    = 7'b0010011;
   localparam logic [6:0] OP_LOAD   = 7'b0000011;
   localparam logic [6:0] OP_STORE  = 7'b0100011;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;
   localparam logic [6:0] OP_JAL    = 7'b1101111;

   localparam logic [2:0] ALU_ADD = 3'd0;
   localparam logic [2:0] ALU_SUB = 3'd1;
   localparam logic [2:0] ALU_AND = 3'd2;
   localparam logic [2:0] ALU_OR  = 3'd3;
   localparam logic [2:0] ALU_SLT = 3'd4;

   // One instruction word seen as R type or I type
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;
      struct packed {
         logic [11:0] imm;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i;
   } instr_u;

endpackage

// ==== hw/dmem_if.sv ====
// One data RAM requester; gnt and rdata are combinational in the request cycle
`timescale 1ns/1ps

interface dmem_if;
   import rv_pkg::*;

   logic               req;
   logic               we;
   logic [DMEM_AW-1:0] idx;
   logic [XLEN-1:0]    wdata;
   logic [XLEN-1:0]    rdata;
   logic               gnt;

   modport requester (output req, we, idx, wdata, input rdata, gnt);
   modport memory (input req, we, idx, wdata, output rdata, gnt);

endinterface

// ==== hw/sram_2p.sv ====
// Contents are undefined after power-up; both read ports are combinational
`timescale 1ns/1ps

module sram_2p #(
   parameter int AW = 9,
   parameter int DW = 32
) (
   input  logic          clk,
   input  logic          we,
   input  logic [AW-1:0] waddr,
   input  logic [DW-1:0] wdata,
   input  logic [AW-1:0] raddr,
   input  logic [AW-1:0] raddr_b,
   output logic [DW-1:0] rdata,
   output logic [DW-1:0] rdata_b
);

   logic [DW-1:0] mem [2**AW];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   assign rdata   = mem[raddr];
   assign rdata_b = mem[raddr_b];

endmodule

// ==== hw/rv_regfile.sv ====
// Reset clears all registers; a write to x0 is dropped
`timescale 1ns/1ps

module rv_regfile (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    we,
   input  logic [4:0]              waddr,
   input  logic [4:0]              raddr_1,
   input  logic [4:0]              raddr_2,
   input  logic [rv_pkg::XLEN-1:0] wdata,
   output logic [rv_pkg::XLEN-1:0] rdata_1,
   output logic [rv_pkg::XLEN-1:0] rdata_2
);
   import rv_pkg::*;

   logic [XLEN-1:0] regs [32];
   logic            wr_ok;

   assign wr_ok = we && (waddr != 5'd0);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_ok) begin
         regs[waddr] <= wdata;
      end
   end

   // Write-through so WB needs no forwarding into decode
   assign rdata_1 = (wr_ok && waddr == raddr_1) ? wdata : regs[raddr_1];
   assign rdata_2 = (wr_ok && waddr == raddr_2) ? wdata : regs[raddr_2];

endmodule

// ==== hw/rv_decode.sv ====
// Only add, sub, and, or, slt, addi, ld, sd, beq and jal; other opcodes become a bubble
`timescale 1ns/1ps

module rv_decode (
   input  rv_pkg::instr_u          instr,
   output logic [rv_pkg::XLEN-1:0] imm,
   output logic [2:0]              alu_code,
   output logic                    alu_src,
   output logic                    reg_write,
   output logic                    mem_read,
   output logic                    mem_write,
   output logic                    mem_to_reg,
   output logic                    branch,
   output logic                    jump,
   output logic                    uses_rs1,
   output logic                    uses_rs2
);
   import rv_pkg::*;

   always_comb begin
      imm        = '0;
      alu_code   = ALU_ADD;
      alu_src    = 1'b0;
      reg_write  = 1'b0;
      mem_read   = 1'b0;
      mem_write  = 1'b0;
      mem_to_reg = 1'b0;
      branch     = 1'b0;
      jump       = 1'b0;
      uses_rs1   = 1'b0;
      uses_rs2   = 1'b0;
      case (instr.r.opcode)
         OP_R: begin
            reg_write = 1'b1;
            uses_rs1  = 1'b1;
            uses_rs2  = 1'b1;
            case (instr.r.funct3)
               3'b010:  alu_code = ALU_SLT;
               3'b110:  alu_code = ALU_OR;
               3'b111:  alu_code = ALU_AND;
               default: alu_code = instr.r.funct7[5] ? ALU_SUB : ALU_ADD;
            endcase
         end
         OP_IMM, OP_LOAD: begin
            imm        = {{(XLEN-12){instr.i.imm[11]}}, instr.i.imm};
            alu_src    = 1'b1;
            reg_write  = 1'b1;
            uses_rs1   = 1'b1;
            mem_read   = (instr.i.opcode == OP_LOAD);
            mem_to_reg = (instr.i.opcode == OP_LOAD);
         end
         OP_STORE: begin
            // S immediate sits in funct7 and rd
            imm       = {{(XLEN-12){instr.r.funct7[6]}}, instr.r.funct7, instr.r.rd};
            alu_src   = 1'b1;
            mem_write = 1'b1;
            uses_rs1  = 1'b1;
            uses_rs2  = 1'b1;
         end
         OP_BRANCH: begin
            imm      = {{(XLEN-13){instr.r.funct7[6]}}, instr.r.funct7[6], instr.r.rd[0],
                        instr.r.funct7[5:0], instr.r.rd[4:1], 1'b0};
            branch   = 1'b1;
            uses_rs1 = 1'b1;
            uses_rs2 = 1'b1;
         end
         OP_JAL: begin
            // J immediate gathered from the I view fields
            imm       = {{(XLEN-21){instr.i.imm[11]}}, instr.i.imm[11], instr.i.rs1,
                         instr.i.funct3, instr.i.imm[0], instr.i.imm[10:1], 1'b0};
            jump      = 1'b1;
            reg_write = 1'b1;
         end
         default: ;
      endcase
   end

endmodule

// ==== hw/rv_core.sv ====
// ld and sd addresses index the data RAM from byte 0 and the upper address bits are ignored
`timescale 1ns/1ps

module rv_core (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       enable,
   input  logic [rv_pkg::ILEN-1:0]    instr,
   output logic [rv_pkg::IMEM_AW-1:0] imem_idx,
   dmem_if.requester                  dmem
);
   import rv_pkg::*;

   logic [XLEN-1:0] pc, id_pc, target;
   instr_u          id_instr;
   logic [XLEN-1:0] dec_imm, rs1_data, rs2_data;
   logic [2:0]      dec_alu_code;
   logic            dec_alu_src, dec_reg_write, dec_mem_read, dec_mem_write;
   logic            dec_mem_to_reg, dec_branch, dec_jump, dec_uses_rs1, dec_uses_rs2;
   logic            load_use, branch_stall, stall, take;

   logic            ex_reg_write, ex_mem_read, ex_mem_write, ex_mem_to_reg;
   logic            ex_alu_src, ex_jump;
   logic [2:0]      ex_alu_code;
   logic [XLEN-1:0] ex_pc, ex_imm, ex_rs1_data, ex_rs2_data;
   logic [4:0]      ex_rs1, ex_rs2, ex_rd;
   logic [XLEN-1:0] fwd_a, fwd_b, alu_b, alu_out, ex_result;

   logic            mem_reg_write, mem_mem_read, mem_mem_write, mem_mem_to_reg;
   logic [XLEN-1:0] mem_result, mem_store_data;
   logic [4:0]      mem_rd;

   logic            wb_reg_write, wb_mem_to_reg;
   logic [XLEN-1:0] wb_result, wb_load_data, wb_data;
   logic [4:0]      wb_rd;

   // Nonzero destination of a writing instruction that feeds this beq
   function automatic logic beq_dep(input logic [4:0] rd, input logic wr);
      return wr && (rd != 5'd0) && (rd == id_instr.r.rs1 || rd == id_instr.r.rs2);
   endfunction

   // EX/MEM wins over MEM/WB
   function automatic logic [XLEN-1:0] forward(input logic [4:0] rs,
                                               input logic [XLEN-1:0] reg_val);
      if (mem_reg_write && mem_rd != 5'd0 && mem_rd == rs) begin
         return mem_result;
      end else if (wb_reg_write && wb_rd != 5'd0 && wb_rd == rs) begin
         return wb_data;
      end
      return reg_val;
   endfunction

   assign imem_idx = pc[IMEM_AW+1:2];

   rv_decode u_decode (
      .instr      (id_instr),
      .imm        (dec_imm),
      .alu_code   (dec_alu_code),
      .alu_src    (dec_alu_src),
      .reg_write  (dec_reg_write),
      .mem_read   (dec_mem_read),
      .mem_write  (dec_mem_write),
      .mem_to_reg (dec_mem_to_reg),
      .branch     (dec_branch),
      .jump       (dec_jump),
      .uses_rs1   (dec_uses_rs1),
      .uses_rs2   (dec_uses_rs2)
   );

   rv_regfile u_regfile (
      .clk     (clk),
      .rst_n   (rst_n),
      .we      (enable && wb_reg_write),
      .waddr   (wb_rd),
      .raddr_1 (id_instr.r.rs1),
      .raddr_2 (id_instr.r.rs2),
      .wdata   (wb_data),
      .rdata_1 (rs1_data),
      .rdata_2 (rs2_data)
   );

   // Hazards and branch resolution in decode
   always_comb begin
      load_use = ex_mem_read && (ex_rd != 5'd0) &&
                 ((dec_uses_rs1 && ex_rd == id_instr.r.rs1) ||
                  (dec_uses_rs2 && ex_rd == id_instr.r.rs2));
      branch_stall = dec_branch &&
                     (beq_dep(ex_rd, ex_reg_write) || beq_dep(mem_rd, mem_reg_write));
      stall  = load_use || branch_stall;
      take   = !stall && (dec_jump || (dec_branch && rs1_data == rs2_data));
      target = id_pc + dec_imm;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc       <= '0;
         id_instr <= '0;
      end else if (enable && !stall) begin
         pc       <= take ? target : pc + 64'd4;
         // Taken branch squashes the instruction behind it
         id_instr <= take ? '0 : instr;
      end
   end

   always_ff @(posedge clk) begin
      if (enable && !stall) begin
         id_pc <= pc;
      end
   end

   // ID/EX, a stall sends a bubble
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_reg_write  <= 1'b0;
         ex_mem_read   <= 1'b0;
         ex_mem_write  <= 1'b0;
         ex_mem_to_reg <= 1'b0;
         ex_alu_src    <= 1'b0;
         ex_jump       <= 1'b0;
         ex_alu_code   <= ALU_ADD;
      end else if (enable) begin
         ex_reg_write  <= dec_reg_write && !stall;
         ex_mem_read   <= dec_mem_read && !stall;
         ex_mem_write  <= dec_mem_write && !stall;
         ex_mem_to_reg <= dec_mem_to_reg && !stall;
         ex_alu_src    <= dec_alu_src && !stall;
         ex_jump       <= dec_jump && !stall;
         ex_alu_code   <= stall ? ALU_ADD : dec_alu_code;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         ex_pc       <= id_pc;
         ex_imm      <= dec_imm;
         ex_rs1_data <= rs1_data;
         ex_rs2_data <= rs2_data;
         ex_rs1      <= id_instr.r.rs1;
         ex_rs2      <= id_instr.r.rs2;
         ex_rd       <= id_instr.i.rd;
      end
   end

   // Execute
   always_comb begin
      fwd_a = forward(ex_rs1, ex_rs1_data);
      fwd_b = forward(ex_rs2, ex_rs2_data);
      alu_b = ex_alu_src ? ex_imm : fwd_b;
      case (ex_alu_code)
         ALU_SUB: alu_out = fwd_a - alu_b;
         ALU_AND: alu_out = fwd_a & alu_b;
         ALU_OR:  alu_out = fwd_a | alu_b;
         ALU_SLT: alu_out = {{(XLEN-1){1'b0}}, $signed(fwd_a) < $signed(alu_b)};
         default: alu_out = fwd_a + alu_b;
      endcase
      // jal links the return address
      ex_result = ex_jump ? ex_pc + 64'd4 : alu_out;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mem_reg_write  <= 1'b0;
         mem_mem_read   <= 1'b0;
         mem_mem_write  <= 1'b0;
         mem_mem_to_reg <= 1'b0;
      end else if (enable) begin
         mem_reg_write  <= ex_reg_write;
         mem_mem_read   <= ex_mem_read;
         mem_mem_write  <= ex_mem_write;
         mem_mem_to_reg <= ex_mem_to_reg;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         mem_result     <= ex_result;
         mem_store_data <= fwd_b;
         mem_rd         <= ex_rd;
      end
   end

   // Core always wins the data RAM
   assign dmem.req   = enable && (mem_mem_read || mem_mem_write);
   assign dmem.we    = mem_mem_write;
   assign dmem.idx   = mem_result[DMEM_AW+2:3];
   assign dmem.wdata = mem_store_data;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_reg_write  <= 1'b0;
         wb_mem_to_reg <= 1'b0;
      end else if (enable) begin
         wb_reg_write  <= mem_reg_write;
         wb_mem_to_reg <= mem_mem_to_reg;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         wb_result    <= mem_result;
         wb_load_data <= dmem.rdata;
         wb_rd        <= mem_rd;
      end
   end

   assign wb_data = wb_mem_to_reg ? wb_load_data : wb_result;

endmodule

// ==== hw/dmem_arbiter.sv ====
// Fixed priority to the core so a steady core stream can hold off the APB side
`timescale 1ns/1ps

module dmem_arbiter (
   dmem_if.memory                        core,
   dmem_if.memory                        apb,
   output logic                          ram_we,
   output logic [rv_pkg::DMEM_AW-1:0]    ram_idx,
   output logic [rv_pkg::XLEN-1:0]       ram_wdata,
   input  logic [rv_pkg::XLEN-1:0]       ram_rdata
);
   import rv_pkg::*;

   logic apb_win;

   assign apb_win = apb.req && !core.req;

   assign core.gnt = core.req;
   assign apb.gnt  = apb_win;

   // Steer the winner onto the single RAM port
   always_comb begin
      if (core.req) begin
         ram_we    = core.we;
         ram_idx   = core.idx;
         ram_wdata = core.wdata;
      end else begin
         ram_we    = apb_win && apb.we;
         ram_idx   = apb.idx;
         ram_wdata = apb.wdata;
      end
   end

   // Read data is shared, only the granted side samples it
   assign core.rdata = ram_rdata;
   assign apb.rdata  = ram_rdata;

endmodule

// ==== hw/apb_host_bridge.sv ====
// Instruction space uses byte addresses with word index paddr[10:2]; other holes give pslverr
`timescale 1ns/1ps

module apb_host_bridge (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       psel,
   input  logic                       penable,
   input  logic                       pwrite,
   input  logic [rv_pkg::APB_AW-1:0]  paddr,
   input  logic [rv_pkg::XLEN-1:0]    pwdata,
   output logic [rv_pkg::XLEN-1:0]    prdata,
   output logic                       pready,
   output logic                       pslverr,
   output logic                       imem_we,
   output logic [rv_pkg::IMEM_AW-1:0] imem_widx,
   output logic [rv_pkg::ILEN-1:0]    imem_wdata,
   input  logic [rv_pkg::ILEN-1:0]    imem_rdata,
   output logic [rv_pkg::IMEM_AW-1:0] imem_ridx_apb,
   dmem_if.requester                  dmem
);
   import rv_pkg::*;

   logic access, sel_imem, sel_dmem, sel_err;

   assign access = psel && penable;

   // Region decoded in the setup phase, held until the transfer ends
   always_ff @(posedge clk) begin
      if (!rst_n || pready) begin
         sel_imem <= 1'b0;
         sel_dmem <= 1'b0;
         sel_err  <= 1'b0;
      end else if (psel && !penable) begin
         sel_imem <= paddr[APB_AW-1:IMEM_AW+2] == IMEM_BASE[APB_AW-1:IMEM_AW+2];
         sel_dmem <= paddr[APB_AW-1:DMEM_AW+3] == DMEM_BASE[APB_AW-1:DMEM_AW+3];
         sel_err  <= paddr[APB_AW-1:IMEM_AW+2] != IMEM_BASE[APB_AW-1:IMEM_AW+2] &&
                     paddr[APB_AW-1:DMEM_AW+3] != DMEM_BASE[APB_AW-1:DMEM_AW+3];
      end
   end

   assign imem_we       = access && sel_imem && pwrite;
   assign imem_widx     = paddr[IMEM_AW+1:2];
   assign imem_wdata    = pwdata[ILEN-1:0];
   assign imem_ridx_apb = paddr[IMEM_AW+1:2];

   // Data requests wait for a free RAM cycle
   assign dmem.req   = access && sel_dmem;
   assign dmem.we    = pwrite;
   assign dmem.idx   = paddr[DMEM_AW+2:3];
   assign dmem.wdata = pwdata;

   assign pready  = access && (sel_imem || sel_err || (sel_dmem && dmem.gnt));
   assign pslverr = access && sel_err;
   assign prdata  = sel_imem ? {{(XLEN-ILEN){1'b0}}, imem_rdata} :
                    sel_dmem ? dmem.rdata : '0;

endmodule

// ==== hw/rv_top.sv ====
// enable low freezes the core while APB still reaches both memories
`timescale 1ns/1ps

module rv_top (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      enable,
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  logic [rv_pkg::APB_AW-1:0] paddr,
   input  logic [rv_pkg::XLEN-1:0]   pwdata,
   output logic [rv_pkg::XLEN-1:0]   prdata,
   output logic                      pready,
   output logic                      pslverr
);
   import rv_pkg::*;

   logic [ILEN-1:0]    instr, imem_wdata, imem_rdata;
   logic [IMEM_AW-1:0] imem_idx, imem_widx, imem_ridx_apb;
   logic               imem_we, ram_we;
   logic [DMEM_AW-1:0] ram_idx;
   logic [XLEN-1:0]    ram_wdata, ram_rdata;

   dmem_if core_dmem ();
   dmem_if apb_dmem ();

   rv_core u_core (
      .clk      (clk),
      .rst_n    (rst_n),
      .enable   (enable),
      .instr    (instr),
      .imem_idx (imem_idx),
      .dmem     (core_dmem.requester)
   );

   apb_host_bridge u_bridge (
      .clk           (clk),
      .rst_n         (rst_n),
      .psel          (psel),
      .penable       (penable),
      .pwrite        (pwrite),
      .paddr         (paddr),
      .pwdata        (pwdata),
      .prdata        (prdata),
      .pready        (pready),
      .pslverr       (pslverr),
      .imem_we       (imem_we),
      .imem_widx     (imem_widx),
      .imem_wdata    (imem_wdata),
      .imem_rdata    (imem_rdata),
      .imem_ridx_apb (imem_ridx_apb),
      .dmem          (apb_dmem.requester)
   );

   dmem_arbiter u_arbiter (
      .core      (core_dmem.memory),
      .apb       (apb_dmem.memory),
      .ram_we    (ram_we),
      .ram_idx   (ram_idx),
      .ram_wdata (ram_wdata),
      .ram_rdata (ram_rdata)
   );

   // Fetch on port a, APB readback on port b
   sram_2p #(.AW(IMEM_AW), .DW(ILEN)) u_imem (
      .clk     (clk),
      .we      (imem_we),
      .waddr   (imem_widx),
      .wdata   (imem_wdata),
      .raddr   (imem_idx),
      .raddr_b (imem_ridx_apb),
      .rdata   (instr),
      .rdata_b (imem_rdata)
   );

   sram_2p #(.AW(DMEM_AW), .DW(XLEN)) u_dmem (
      .clk     (clk),
      .we      (ram_we),
      .waddr   (ram_idx),
      .wdata   (ram_wdata),
      .raddr   (ram_idx),
      .raddr_b (ram_idx),
      .rdata   (ram_rdata),
      .rdata_b ()
   );

endmodule

// ==== bench/tb_programs.svh ====
// Encoders follow the RV64I formats; programs address the data RAM from byte 0
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
   return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] i_word(input int imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opcode);
   logic [11:0] im;
   im = imm[11:0];
   return {im, rs1, f3, rd, opcode};
endfunction

function automatic logic [31:0] s_word(input int imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
   logic [11:0] im;
   im = imm[11:0];
   return {im[11:5], rs2, rs1, 3'b011, im[4:0], 7'b0100011};
endfunction

// Branch offsets are in bytes relative to the beq itself
function automatic logic [31:0] b_word(input int imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
   logic [12:0] im;
   im = imm[12:0];
   return {im[12], im[10:5], rs2, rs1, 3'b000, im[4:1], im[11], 7'b1100011};
endfunction

function automatic logic [31:0] j_word(input int imm, input logic [4:0] rd);
   logic [20:0] im;
   im = imm[20:0];
   return {im[20], im[10:1], im[11], im[19:12], rd, 7'b1101111};
endfunction

task automatic emit(input logic [31:0] word);
   prog.push_back(word);
endtask

// Shorthands for the supported subset
task automatic add_op(input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
   emit(r_word(7'h00, rs2, rs1, 3'b000, rd));
endtask

task automatic addi_op(input logic [4:0] rd, input logic [4:0] rs1, input int imm);
   emit(i_word(imm, rs1, 3'b000, rd, 7'b0010011));
endtask

task automatic ld_op(input logic [4:0] rd, input logic [4:0] rs1, input int imm);
   emit(i_word(imm, rs1, 3'b011, rd, 7'b0000011));
endtask

task automatic sd_op(input logic [4:0] rs2, input logic [4:0] rs1, input int imm);
   emit(s_word(imm, rs2, rs1));
endtask

// Marker store followed by a jump to itself
task automatic done_tail();
   addi_op(5'd31, 5'd0, MARKER);
   sd_op(5'd31, 5'd0, DONE_OFS);
   emit(j_word(0, 5'd0));
endtask

task automatic alu_program();
   prog.delete();
   ld_op(5'd1, 5'd0, 0);
   ld_op(5'd2, 5'd0, 8);
   add_op(5'd3, 5'd1, 5'd2);
   emit(r_word(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
   emit(r_word(7'h00, 5'd1, 5'd4, 3'b111, 5'd5));
   emit(r_word(7'h00, 5'd3, 5'd5, 3'b110, 5'd6));
   emit(r_word(7'h00, 5'd1, 5'd6, 3'b010, 5'd7));
   addi_op(5'd8, 5'd7, -123);
   sd_op(5'd3, 5'd0, 16);
   sd_op(5'd4, 5'd0, 24);
   sd_op(5'd5, 5'd0, 32);
   sd_op(5'd6, 5'd0, 40);
   sd_op(5'd7, 5'd0, 48);
   sd_op(5'd8, 5'd0, 56);
   done_tail();
endtask

task automatic load_use_program();
   prog.delete();
   addi_op(5'd2, 5'd0, 77);
   ld_op(5'd1, 5'd0, 64);
   add_op(5'd3, 5'd1, 5'd2);
   sd_op(5'd3, 5'd0, 72);
   done_tail();
endtask

task automatic branch_program(output int jal_idx);
   prog.delete();
   addi_op(5'd1, 5'd0, 5);
   addi_op(5'd2, 5'd0, 5);
   emit(b_word(8, 5'd2, 5'd1));
   sd_op(5'd1, 5'd0, 80);
   addi_op(5'd3, 5'd0, 9);
   emit(b_word(8, 5'd3, 5'd1));
   sd_op(5'd3, 5'd0, 88);
   jal_idx = prog.size();
   emit(j_word(8, 5'd4));
   sd_op(5'd1, 5'd0, 96);
   sd_op(5'd4, 5'd0, 104);
   done_tail();
endtask

// Counts to n, storing each count
task automatic store_loop_program(input int n);
   prog.delete();
   addi_op(5'd1, 5'd0, 0);
   addi_op(5'd2, 5'd0, n);
   addi_op(5'd1, 5'd1, 1);
   sd_op(5'd1, 5'd0, 112);
   emit(b_word(8, 5'd2, 5'd1));
   emit(j_word(-12, 5'd0));
   done_tail();
endtask

`endif

// ==== bench/tb_rv_top.sv ====
// APB transfers start on a falling edge and leave one idle cycle between them
`timescale 1ns/1ps

module tb_rv_top;

   localparam logic [15:0] DMEM     = 16'h2000;
   localparam int          DONE_OFS = 2000;
   localparam int          MARKER   = 'h5A5;
   localparam int          APB_WAIT = 200;
   localparam int          RUN_WAIT = 2000;
   localparam int          LOOPS    = 200;

   logic        clk, rst_n, enable;
   logic        psel, penable, pwrite;
   logic [15:0] paddr;
   logic [63:0] pwdata, prdata;
   logic        pready, pslverr;

   logic [31:0] prog[$];
   int          errors, tests, failed_tests;

   `include "tb_programs.svh"

   rv_top UUT (
      .clk     (clk),
      .rst_n   (rst_n),
      .enable  (enable),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   always #2 clk = ~clk;

   // APB protocol rules on the slave outputs
   assert property (@(posedge clk) disable iff (!rst_n) pready |-> (psel && penable))
      else begin
         errors++;
         $display("pready rose outside an access phase");
      end
   assert property (@(posedge clk) disable iff (!rst_n) pslverr |-> pready)
      else begin
         errors++;
         $display("pslverr rose without pready");
      end

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp)
         else begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
         end
   endtask

   task automatic apply_reset();
      @(negedge clk);
      rst_n = 1'b0;
      repeat (3) @(negedge clk);
      rst_n = 1'b1;
   endtask

   task automatic apb_access(input logic wr, input logic [15:0] addr,
                             input logic [63:0] wdata, output logic [63:0] rdata,
                             output logic err);
      int  cnt;
      logic done;
      cnt   = 0;
      done  = 1'b0;
      rdata = '0;
      err   = 1'b0;
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      while (!done && cnt < APB_WAIT) begin
         // Outputs are settled in the middle of the low phase
         #1;
         if (pready) begin
            done  = 1'b1;
            rdata = prdata;
            err   = pslverr;
         end
         @(negedge clk);
         cnt++;
      end
      psel    = 1'b0;
      penable = 1'b0;
      if (!done) begin
         errors++;
         $display("APB transfer at %h never completed", addr);
      end
   endtask

   task automatic apb_write(input logic [15:0] addr, input logic [63:0] data);
      logic [63:0] unused;
      logic        err;
      apb_access(1'b1, addr, data, unused, err);
      check_value("pslverr", {63'd0, err}, 64'd0);
   endtask

   task automatic apb_read(input logic [15:0] addr, output logic [63:0] data);
      logic err;
      apb_access(1'b0, addr, '0, data, err);
      check_value("pslverr", {63'd0, err}, 64'd0);
   endtask

   // Reset, load the program, clear the marker and start the core
   task automatic run_program();
      enable = 1'b0;
      apply_reset();
      for (int i = 0; i < prog.size(); i++) begin
         apb_write(16'(4 * i), {32'd0, prog[i]});
      end
      apb_write(DMEM + 16'(DONE_OFS), 64'd0);
      @(negedge clk);
      enable = 1'b1;
   endtask

   task automatic wait_done();
      logic [63:0] v;
      int          cnt;
      cnt = 0;
      v   = '0;
      while (v != 64'(MARKER) && cnt < RUN_WAIT) begin
         apb_read(DMEM + 16'(DONE_OFS), v);
         cnt++;
      end
      if (v != 64'(MARKER)) begin
         errors++;
         $display("Program never stored its done marker");
      end
      @(negedge clk);
      enable = 1'b0;
   endtask

   task automatic finish_test(input string name, input int errs_before);
      tests++;
      if (errors != errs_before) begin
         failed_tests++;
         $display("%s: failed", name);
      end else begin
         $display("%s: passed", name);
      end
   endtask

   initial begin
      logic [63:0] a, b, c, v, r3, r4, r5, r6, r7, r8;
      logic        err;
      int          e0, jal_idx;

      clk = 1'b0;
      rst_n = 1'b0;
      enable = 1'b0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      errors = 0;
      tests = 0;
      failed_tests = 0;
      void'($urandom(2071));
      apply_reset();

      // APB access with the core idle
      e0 = errors;
      a = {$urandom, $urandom};
      apb_write(16'h0010, a);
      apb_read(16'h0010, v);
      check_value("imem readback", v, {32'd0, a[31:0]});
      b = {$urandom, $urandom};
      apb_write(DMEM + 16'h0040, b);
      apb_read(DMEM + 16'h0040, v);
      check_value("dmem readback", v, b);
      c = {$urandom, $urandom};
      apb_write(16'h0000, c);
      apb_access(1'b1, 16'h1000, ~c, v, err);
      check_value("pslverr on hole", {63'd0, err}, 64'd1);
      apb_read(16'h0000, v);
      check_value("imem after hole write", v, {32'd0, c[31:0]});
      finish_test("apb access", e0);

      // ALU chain with forwarding
      e0 = errors;
      a = {$urandom, $urandom};
      b = {$urandom, $urandom};
      apb_write(DMEM + 16'd0, a);
      apb_write(DMEM + 16'd8, b);
      alu_program();
      run_program();
      wait_done();
      r3 = a + b;
      r4 = r3 - a;
      r5 = r4 & a;
      r6 = r5 | r3;
      r7 = ($signed(r6) < $signed(a)) ? 64'd1 : 64'd0;
      r8 = r7 - 64'd123;
      apb_read(DMEM + 16'd16, v);
      check_value("add result", v, r3);
      apb_read(DMEM + 16'd24, v);
      check_value("sub result", v, r4);
      apb_read(DMEM + 16'd32, v);
      check_value("and result", v, r5);
      apb_read(DMEM + 16'd40, v);
      check_value("or result", v, r6);
      apb_read(DMEM + 16'd48, v);
      check_value("slt result", v, r7);
      apb_read(DMEM + 16'd56, v);
      check_value("addi result", v, r8);
      finish_test("alu forwarding", e0);

      // Load followed at once by its user
      e0 = errors;
      c = {$urandom, $urandom};
      apb_write(DMEM + 16'd64, c);
      load_use_program();
      run_program();
      wait_done();
      apb_read(DMEM + 16'd72, v);
      check_value("load-use sum", v, c + 64'd77);
      finish_test("load use", e0);

      // Branches and jal
      e0 = errors;
      a = {$urandom, $urandom};
      b = {$urandom, $urandom};
      apb_write(DMEM + 16'd80, a);
      apb_write(DMEM + 16'd96, b);
      apb_write(DMEM + 16'd88, 64'd0);
      branch_program(jal_idx);
      run_program();
      wait_done();
      apb_read(DMEM + 16'd80, v);
      check_value("skipped by beq", v, a);
      apb_read(DMEM + 16'd88, v);
      check_value("beq fall-through", v, 64'd9);
      apb_read(DMEM + 16'd96, v);
      check_value("skipped by jal", v, b);
      apb_read(DMEM + 16'd104, v);
      check_value("jal link", v, 64'(4 * jal_idx + 4));
      finish_test("branch and jump", e0);

      // APB reads while the core keeps storing
      e0 = errors;
      c = {$urandom, $urandom};
      apb_write(DMEM + 16'd120, c);
      store_loop_program(LOOPS);
      run_program();
      for (int i = 0; i < 10; i++) begin
         // Idle gap shifts each read against the core's store cycle
         repeat (2) @(negedge clk);
         apb_read(DMEM + 16'd120, v);
         check_value("preload under traffic", v, c);
      end
      wait_done();
      apb_read(DMEM + 16'd112, v);
      check_value("loop count", v, 64'(LOOPS));
      finish_test("arbitration", e0);

      $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+bench
hw/rv_pkg.sv
hw/dmem_if.sv
hw/sram_2p.sv
hw/rv_regfile.sv
hw/rv_decode.sv
hw/rv_core.sv
hw/dmem_arbiter.sv
hw/apb_host_bridge.sv
hw/rv_top.sv
bench/tb_rv_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator and run; pass only when the log holds the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_rv_top -o sim_rv_top
./obj_dir/sim_rv_top | tee sim.log

if grep -q "^TEST OK$" sim.log; then
   exit 0
else
   exit 1
fi
